//--- hdl/procyon_pkg.sv
// Rename subsystem shared types

package procyon_pkg;

    // Width of one architectural register value
    localparam int DATA_WIDTH = 32;

    // Register number width, which sets the architectural register count
    localparam int REG_ADDR_WIDTH = 5;

    // Number of architectural registers including the hardwired r0
    localparam int REG_COUNT = 2 ** REG_ADDR_WIDTH;

    // Rename tag width, which sets the reorder buffer depth
    localparam int TAG_WIDTH = 3;

    // Number of reorder buffer entries
    // Pointers of TAG_WIDTH bits wrap around this depth on their own
    localparam int ROB_DEPTH = 2 ** TAG_WIDTH;

    // A register value as stored in the register map and the reorder buffer
    typedef logic [DATA_WIDTH-1:0] procyon_data_t;

    // An architectural register number
    typedef logic [REG_ADDR_WIDTH-1:0] procyon_reg_t;

    // A reorder buffer entry index, also used as the rename tag
    typedef logic [TAG_WIDTH-1:0] procyon_tag_t;

    // Reorder buffer occupancy state
    // EMPTY holds no entries and ACTIVE holds at least one
    // FULL means every entry is taken and allocation is refused
    typedef enum logic [1:0] {
        EMPTY  = 2'b00,
        ACTIVE = 2'b01,
        FULL   = 2'b10
    } rob_state_e;

endpackage

//--- hdl/register_map.sv
// Register map with rename tags
`timescale 1ns/1ps

module register_map (
    input  logic                      clk,
    input  logic                      n_rst,

    // Flush marks every register ready again
    input  logic                      i_flush,

    // Retire write from the reorder buffer head
    input  logic                      i_retire_wr_en,
    input  procyon_pkg::procyon_reg_t  i_retire_rdest,
    input  procyon_pkg::procyon_tag_t  i_retire_tag,
    input  procyon_pkg::procyon_data_t i_retire_data,

    // Rename write for the destination of a new dispatch
    input  logic                      i_rename_wr_en,
    input  procyon_pkg::procyon_reg_t  i_rename_rdest,
    input  procyon_pkg::procyon_tag_t  i_rename_tag,

    // Two source operand lookups
    input  procyon_pkg::procyon_reg_t  i_lookup_rsrc0,
    input  procyon_pkg::procyon_reg_t  i_lookup_rsrc1,
    output logic                      o_lookup_rdy0,
    output logic                      o_lookup_rdy1,
    output procyon_pkg::procyon_tag_t  o_lookup_tag0,
    output procyon_pkg::procyon_tag_t  o_lookup_tag1,
    output procyon_pkg::procyon_data_t o_lookup_data0,
    output procyon_pkg::procyon_data_t o_lookup_data1
);

    import procyon_pkg::*;

    // Per-register storage, split so only the ready bits carry a reset
    procyon_data_t        data_q [REG_COUNT];
    procyon_tag_t         tag_q  [REG_COUNT];
    logic [REG_COUNT-1:0] rdy_q;

    // Writes aimed at r0 are discarded, the result is thrown away
    logic                 retire_en;
    logic                 rename_en;

    assign retire_en = i_retire_wr_en && (i_retire_rdest != '0);
    assign rename_en = i_rename_wr_en && (i_rename_rdest != '0);

    // Lookups are plain reads of the current state
    // A same-cycle rename of a source is not visible, so the old mapping is seen
    assign o_lookup_rdy0  = rdy_q[i_lookup_rsrc0];
    assign o_lookup_tag0  = tag_q[i_lookup_rsrc0];
    assign o_lookup_data0 = data_q[i_lookup_rsrc0];
    assign o_lookup_rdy1  = rdy_q[i_lookup_rsrc1];
    assign o_lookup_tag1  = tag_q[i_lookup_rsrc1];
    assign o_lookup_data1 = data_q[i_lookup_rsrc1];

    // Data and tag arrays, written by retire and rename respectively
    always_ff @(posedge clk) begin
        for (int i = 0; i < REG_COUNT; i++) begin
            if (i == 0) begin
                // r0 is rewritten with zero every cycle
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end else begin
                if (retire_en && (i_retire_rdest == procyon_reg_t'(i))) begin
                    data_q[i] <= i_retire_data;
                end
                if (rename_en && (i_rename_rdest == procyon_reg_t'(i))) begin
                    tag_q[i] <= i_rename_tag;
                end
            end
        end
    end

    // Ready bits come out of reset set, since no instruction is in flight
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '1;
        end else begin
            for (int i = 0; i < REG_COUNT; i++) begin
                if (i == 0) begin
                    rdy_q[i] <= 1'b1;
                end else if (i_flush) begin
                    // Flushed tags will never complete, the stored data is the last
                    // retired value and so already correct
                    rdy_q[i] <= 1'b1;
                end else if (rename_en && (i_rename_rdest == procyon_reg_t'(i))) begin
                    // A new producer wins over a retire to the same register
                    rdy_q[i] <= 1'b0;
                end else if (retire_en && (i_retire_rdest == procyon_reg_t'(i)) &&
                             (i_retire_tag == tag_q[i])) begin
                    // Only the latest producer may make the register ready
                    rdy_q[i] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/reorder_buffer.sv
// Reorder buffer for in-order retire
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                      clk,
    input  logic                      n_rst,

    // Flush empties the buffer
    input  logic                      i_flush,

    // Allocation at the tail, the tag is the tail index
    input  logic                      i_alloc_en,
    input  procyon_pkg::procyon_reg_t  i_alloc_rdest,
    output procyon_pkg::procyon_tag_t  o_alloc_tag,
    output logic                      o_full,

    // Common data bus completion
    input  logic                      i_cdb_valid,
    input  procyon_pkg::procyon_tag_t  i_cdb_tag,
    input  procyon_pkg::procyon_data_t i_cdb_data,

    // Operand bypass lookups by tag
    input  procyon_pkg::procyon_tag_t  i_bypass_tag0,
    input  procyon_pkg::procyon_tag_t  i_bypass_tag1,
    output logic                      o_bypass_done0,
    output logic                      o_bypass_done1,
    output procyon_pkg::procyon_data_t o_bypass_data0,
    output procyon_pkg::procyon_data_t o_bypass_data1,

    // Retire of the head entry toward the register map
    output logic                      o_retire_valid,
    output procyon_pkg::procyon_reg_t  o_retire_rdest,
    output procyon_pkg::procyon_tag_t  o_retire_tag,
    output procyon_pkg::procyon_data_t o_retire_data
);

    import procyon_pkg::*;

    // Entry payload, written on allocation and on completion
    procyon_reg_t         rdest_q [ROB_DEPTH];
    procyon_data_t        data_q  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    // Head is the oldest entry and tail the next free one
    procyon_tag_t         head_q;
    procyon_tag_t         tail_q;
    rob_state_e           state_q;
    rob_state_e           state_d;

    logic                 alloc_ok;
    logic                 retire;
    logic                 cdb_ok;

    // Allocation is refused when full and squashed by a flush
    assign alloc_ok = i_alloc_en && (state_q != FULL) && !i_flush;
    assign cdb_ok   = i_cdb_valid && !i_flush;

    // The head retires in the cycle after its done bit was set
    assign retire = (state_q != EMPTY) && done_q[head_q];

    assign o_alloc_tag = tail_q;
    assign o_full      = (state_q == FULL);

    assign o_retire_valid = retire;
    assign o_retire_rdest = rdest_q[head_q];
    assign o_retire_tag   = head_q;
    assign o_retire_data  = data_q[head_q];

    // Bypass answers from state registered before this cycle
    assign o_bypass_done0 = done_q[i_bypass_tag0];
    assign o_bypass_data0 = data_q[i_bypass_tag0];
    assign o_bypass_done1 = done_q[i_bypass_tag1];
    assign o_bypass_data1 = data_q[i_bypass_tag1];

    // Occupancy FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            EMPTY: begin
                // Nothing can retire from an empty buffer
                if (alloc_ok) state_d = ACTIVE;
            end
            ACTIVE: begin
                if (alloc_ok && !retire && ((tail_q + 1'b1) == head_q)) begin
                    state_d = FULL;
                end else if (retire && !alloc_ok && ((head_q + 1'b1) == tail_q)) begin
                    state_d = EMPTY;
                end
            end
            FULL: begin
                // Allocation is blocked here, so a retire always frees one slot
                if (retire) state_d = ACTIVE;
            end
            default: state_d = EMPTY;
        endcase
        if (i_flush) state_d = EMPTY;
    end

    // Control state and pointers
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= EMPTY;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            state_q <= state_d;
            if (i_flush) begin
                head_q <= '0;
                tail_q <= '0;
            end else begin
                if (retire) head_q <= head_q + 1'b1;
                if (alloc_ok) tail_q <= tail_q + 1'b1;
            end
        end
    end

    // Done bits are cleared on retire and on reuse of the slot
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            done_q <= '0;
        end else if (i_flush) begin
            done_q <= '0;
        end else begin
            if (retire) done_q[head_q] <= 1'b0;
            if (alloc_ok) done_q[tail_q] <= 1'b0;
            if (cdb_ok) done_q[i_cdb_tag] <= 1'b1;
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (alloc_ok) rdest_q[tail_q] <= i_alloc_rdest;
        if (cdb_ok) data_q[i_cdb_tag] <= i_cdb_data;
    end

endmodule

//--- hdl/dispatch_stage.sv
// Dispatch and operand resolve stage
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                      clk,
    input  logic                      n_rst,

    // Incoming dispatch
    input  logic                      i_dispatch_valid,
    input  procyon_pkg::procyon_reg_t  i_dispatch_rsrc0,
    input  procyon_pkg::procyon_reg_t  i_dispatch_rsrc1,
    input  procyon_pkg::procyon_reg_t  i_dispatch_rdest,
    input  logic                      i_flush,

    // Register map lookup
    output procyon_pkg::procyon_reg_t  o_lookup_rsrc0,
    output procyon_pkg::procyon_reg_t  o_lookup_rsrc1,
    input  logic                      i_lookup_rdy0,
    input  logic                      i_lookup_rdy1,
    input  procyon_pkg::procyon_tag_t  i_lookup_tag0,
    input  procyon_pkg::procyon_tag_t  i_lookup_tag1,
    input  procyon_pkg::procyon_data_t i_lookup_data0,
    input  procyon_pkg::procyon_data_t i_lookup_data1,

    // Reorder buffer bypass lookup
    output procyon_pkg::procyon_tag_t  o_bypass_tag0,
    output procyon_pkg::procyon_tag_t  o_bypass_tag1,
    input  logic                      i_bypass_done0,
    input  logic                      i_bypass_done1,
    input  procyon_pkg::procyon_data_t i_bypass_data0,
    input  procyon_pkg::procyon_data_t i_bypass_data1,

    // Tag allocation and rename write
    output logic                      o_alloc_en,
    output procyon_pkg::procyon_reg_t  o_alloc_rdest,
    input  procyon_pkg::procyon_tag_t  i_alloc_tag,
    output logic                      o_rename_wr_en,
    output procyon_pkg::procyon_reg_t  o_rename_rdest,
    output procyon_pkg::procyon_tag_t  o_rename_tag,

    // Issue strobe, one cycle after dispatch
    output logic                      o_issue_valid,
    output procyon_pkg::procyon_tag_t  o_issue_tag,
    output logic                      o_issue_rdy0,
    output logic                      o_issue_rdy1,
    output procyon_pkg::procyon_tag_t  o_issue_src_tag0,
    output procyon_pkg::procyon_tag_t  o_issue_src_tag1,
    output procyon_pkg::procyon_data_t o_issue_data0,
    output procyon_pkg::procyon_data_t o_issue_data1
);

    import procyon_pkg::*;

    // A flush in the same cycle squashes the dispatch entirely
    logic          dispatch_ok;
    logic          rdy0;
    logic          rdy1;
    procyon_data_t data0;
    procyon_data_t data1;

    assign dispatch_ok = i_dispatch_valid && !i_flush;

    assign o_alloc_en     = dispatch_ok;
    assign o_alloc_rdest  = i_dispatch_rdest;
    assign o_rename_wr_en = dispatch_ok;
    assign o_rename_rdest = i_dispatch_rdest;
    assign o_rename_tag   = i_alloc_tag;

    assign o_lookup_rsrc0 = i_dispatch_rsrc0;
    assign o_lookup_rsrc1 = i_dispatch_rsrc1;

    // A register that is not ready is waiting on the tagged entry, so ask the buffer
    assign o_bypass_tag0 = i_lookup_tag0;
    assign o_bypass_tag1 = i_lookup_tag1;

    // Register map data first, then a done buffer entry, else wait on the tag
    assign rdy0  = i_lookup_rdy0 || i_bypass_done0;
    assign data0 = i_lookup_rdy0 ? i_lookup_data0 : i_bypass_data0;
    assign rdy1  = i_lookup_rdy1 || i_bypass_done1;
    assign data1 = i_lookup_rdy1 ? i_lookup_data1 : i_bypass_data1;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_issue_valid <= 1'b0;
        end else begin
            o_issue_valid <= dispatch_ok;
        end
    end

    // Issue payload is only meaningful alongside the strobe
    always_ff @(posedge clk) begin
        if (dispatch_ok) begin
            o_issue_tag      <= i_alloc_tag;
            o_issue_rdy0     <= rdy0;
            o_issue_rdy1     <= rdy1;
            o_issue_src_tag0 <= i_lookup_tag0;
            o_issue_src_tag1 <= i_lookup_tag1;
            o_issue_data0    <= data0;
            o_issue_data1    <= data1;
        end
    end

endmodule

//--- hdl/rename_top.sv
// Register rename subsystem top
`timescale 1ns/1ps

module rename_top (
    input  logic                      clk,
    input  logic                      n_rst,

    input  logic                      i_dispatch_valid,
    input  procyon_pkg::procyon_reg_t  i_dispatch_rsrc0,
    input  procyon_pkg::procyon_reg_t  i_dispatch_rsrc1,
    input  procyon_pkg::procyon_reg_t  i_dispatch_rdest,

    input  logic                      i_cdb_valid,
    input  procyon_pkg::procyon_tag_t  i_cdb_tag,
    input  procyon_pkg::procyon_data_t i_cdb_data,

    input  logic                      i_flush,

    output logic                      o_issue_valid,
    output procyon_pkg::procyon_tag_t  o_issue_tag,
    output logic                      o_issue_rdy0,
    output logic                      o_issue_rdy1,
    output procyon_pkg::procyon_tag_t  o_issue_src_tag0,
    output procyon_pkg::procyon_tag_t  o_issue_src_tag1,
    output procyon_pkg::procyon_data_t o_issue_data0,
    output procyon_pkg::procyon_data_t o_issue_data1,

    output logic                      o_retire_valid,
    output procyon_pkg::procyon_reg_t  o_retire_rdest,
    output procyon_pkg::procyon_data_t o_retire_data,

    output logic                      o_rob_full
);

    import procyon_pkg::*;

    // Register map lookup between dispatch and map
    procyon_reg_t  lookup_rsrc0, lookup_rsrc1;
    logic          lookup_rdy0, lookup_rdy1;
    procyon_tag_t  lookup_tag0, lookup_tag1;
    procyon_data_t lookup_data0, lookup_data1;

    // Bypass lookup between dispatch and buffer
    procyon_tag_t  bypass_tag0, bypass_tag1;
    logic          bypass_done0, bypass_done1;
    procyon_data_t bypass_data0, bypass_data1;

    // Allocation and rename
    logic          alloc_en;
    procyon_reg_t  alloc_rdest;
    procyon_tag_t  alloc_tag;
    logic          rename_wr_en;
    procyon_reg_t  rename_rdest;
    procyon_tag_t  rename_tag;

    // Retire tag only goes to the map, the rest also leaves the top
    procyon_tag_t  retire_tag;

    dispatch_stage dispatch_stage_i (
        .clk, .n_rst,
        .i_dispatch_valid, .i_dispatch_rsrc0, .i_dispatch_rsrc1, .i_dispatch_rdest,
        .i_flush,
        .o_lookup_rsrc0(lookup_rsrc0), .o_lookup_rsrc1(lookup_rsrc1),
        .i_lookup_rdy0(lookup_rdy0), .i_lookup_rdy1(lookup_rdy1),
        .i_lookup_tag0(lookup_tag0), .i_lookup_tag1(lookup_tag1),
        .i_lookup_data0(lookup_data0), .i_lookup_data1(lookup_data1),
        .o_bypass_tag0(bypass_tag0), .o_bypass_tag1(bypass_tag1),
        .i_bypass_done0(bypass_done0), .i_bypass_done1(bypass_done1),
        .i_bypass_data0(bypass_data0), .i_bypass_data1(bypass_data1),
        .o_alloc_en(alloc_en), .o_alloc_rdest(alloc_rdest), .i_alloc_tag(alloc_tag),
        .o_rename_wr_en(rename_wr_en), .o_rename_rdest(rename_rdest),
        .o_rename_tag(rename_tag),
        .o_issue_valid, .o_issue_tag, .o_issue_rdy0, .o_issue_rdy1,
        .o_issue_src_tag0, .o_issue_src_tag1, .o_issue_data0, .o_issue_data1
    );

    reorder_buffer reorder_buffer_i (
        .clk, .n_rst, .i_flush,
        .i_alloc_en(alloc_en), .i_alloc_rdest(alloc_rdest), .o_alloc_tag(alloc_tag),
        .o_full(o_rob_full),
        .i_cdb_valid, .i_cdb_tag, .i_cdb_data,
        .i_bypass_tag0(bypass_tag0), .i_bypass_tag1(bypass_tag1),
        .o_bypass_done0(bypass_done0), .o_bypass_done1(bypass_done1),
        .o_bypass_data0(bypass_data0), .o_bypass_data1(bypass_data1),
        .o_retire_valid, .o_retire_rdest, .o_retire_tag(retire_tag), .o_retire_data
    );

    register_map register_map_i (
        .clk, .n_rst, .i_flush,
        .i_retire_wr_en(o_retire_valid), .i_retire_rdest(o_retire_rdest),
        .i_retire_tag(retire_tag), .i_retire_data(o_retire_data),
        .i_rename_wr_en(rename_wr_en), .i_rename_rdest(rename_rdest),
        .i_rename_tag(rename_tag),
        .i_lookup_rsrc0(lookup_rsrc0), .i_lookup_rsrc1(lookup_rsrc1),
        .o_lookup_rdy0(lookup_rdy0), .o_lookup_rdy1(lookup_rdy1),
        .o_lookup_tag0(lookup_tag0), .o_lookup_tag1(lookup_tag1),
        .o_lookup_data0(lookup_data0), .o_lookup_data1(lookup_data1)
    );

endmodule

//--- dv/tb_rename_top.sv
// Rename subsystem testbench
`timescale 1ns/1ps

module tb_rename_top;

    import procyon_pkg::*;

    localparam int WAIT_LIMIT  = 64;
    localparam int PICK_RANDOM = 0;
    localparam int PICK_OLDEST = 1;
    localparam int PICK_NEWEST = 2;

    // Issue fields that one dispatch is expected to produce
    typedef struct packed {
        procyon_tag_t  tag;
        logic          rdy0;
        procyon_tag_t  src_tag0;
        procyon_data_t data0;
        logic          rdy1;
        procyon_tag_t  src_tag1;
        procyon_data_t data1;
    } issue_t;

    logic          clk = 1'b0;
    logic          n_rst = 1'b0;
    logic          i_dispatch_valid = 1'b0;
    procyon_reg_t  i_dispatch_rsrc0 = '0;
    procyon_reg_t  i_dispatch_rsrc1 = '0;
    procyon_reg_t  i_dispatch_rdest = '0;
    logic          i_cdb_valid = 1'b0;
    procyon_tag_t  i_cdb_tag = '0;
    procyon_data_t i_cdb_data = '0;
    logic          i_flush = 1'b0;

    logic          o_issue_valid;
    procyon_tag_t  o_issue_tag;
    logic          o_issue_rdy0;
    logic          o_issue_rdy1;
    procyon_tag_t  o_issue_src_tag0;
    procyon_tag_t  o_issue_src_tag1;
    procyon_data_t o_issue_data0;
    procyon_data_t o_issue_data1;
    logic          o_retire_valid;
    procyon_reg_t  o_retire_rdest;
    procyon_data_t o_retire_data;
    logic          o_rob_full;

    // Reference copy of the register map
    logic [REG_COUNT-1:0] m_rdy;
    procyon_tag_t         m_tag [REG_COUNT];
    procyon_data_t        m_data [REG_COUNT];

    // Reference copy of the reorder buffer
    procyon_reg_t         m_rob_rdest [ROB_DEPTH];
    procyon_data_t        m_rob_data [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] m_rob_done;
    procyon_tag_t         m_head;
    procyon_tag_t         m_tail;
    int                   m_count;

    // Issues still owed by the DUT and allocated tags not yet completed
    issue_t               exp_issue [$];
    procyon_tag_t         pending [$];

    logic [31:0]          lfsr_state = 32'h773d2cff;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   issue_checks = 0;
    int                   retire_checks = 0;

    rename_top rename_top_i (.*);

    always #20 clk = ~clk;

    // Galois LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else lfsr_state = lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Map data when ready, then the data of a done entry, and otherwise a wait on the tag
    function automatic void resolve_src(input procyon_reg_t r, output logic rdy,
                                        output procyon_tag_t tag, output procyon_data_t data);
        tag = m_tag[r];
        if (m_rdy[r]) begin
            rdy  = 1'b1;
            data = m_data[r];
        end else if (m_rob_done[m_tag[r]]) begin
            rdy  = 1'b1;
            data = m_rob_data[m_tag[r]];
        end else begin
            rdy  = 1'b0;
            data = '0;
        end
    endfunction

    // Reference function that applies one clock edge with the current inputs
    function automatic void model_edge();
        issue_t       e;
        logic         retire;
        procyon_reg_t rr;
        retire = (m_count > 0) && m_rob_done[m_head];
        rr = m_rob_rdest[m_head];
        // Operands come from the state before this edge
        if (i_dispatch_valid && !i_flush) begin
            e.tag = m_tail;
            resolve_src(i_dispatch_rsrc0, e.rdy0, e.src_tag0, e.data0);
            resolve_src(i_dispatch_rsrc1, e.rdy1, e.src_tag1, e.data1);
            exp_issue.push_back(e);
        end
        // The retire write lands even on a flush edge
        if (retire) begin
            if (rr != '0) begin
                m_data[rr] = m_rob_data[m_head];
                if (m_tag[rr] == m_head) m_rdy[rr] = 1'b1;
            end
            m_rob_done[m_head] = 1'b0;
            m_head = m_head + 1'b1;
            m_count--;
        end
        if (i_flush) begin
            m_rdy = '1;
            m_rob_done = '0;
            m_head = '0;
            m_tail = '0;
            m_count = 0;
            pending.delete();
        end else begin
            if (i_dispatch_valid) begin
                m_rob_rdest[m_tail] = i_dispatch_rdest;
                m_rob_done[m_tail] = 1'b0;
                // Rename after retire so a new producer keeps the register not ready
                if (i_dispatch_rdest != '0) begin
                    m_rdy[i_dispatch_rdest] = 1'b0;
                    m_tag[i_dispatch_rdest] = m_tail;
                end
                pending.push_back(m_tail);
                m_tail = m_tail + 1'b1;
                m_count++;
            end
            if (i_cdb_valid) begin
                m_rob_done[i_cdb_tag] = 1'b1;
                m_rob_data[i_cdb_tag] = i_cdb_data;
            end
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAIL at %0t ns %s expected %0h actual %0h", $time, name, exp, act);
    endtask

    // The issue owed from the last edge must appear now and no other
    task automatic check_issue();
        issue_t e;
        if (exp_issue.size() == 0) begin
            if (o_issue_valid !== 1'b0) begin
                errors++;
                $display("Issue strobe at %0t ns without any dispatch before it", $time);
            end
        end else begin
            e = exp_issue.pop_front();
            issue_checks++;
            if (o_issue_valid !== 1'b1) begin
                report_mismatch("o_issue_valid", 32'd1, 32'(o_issue_valid));
            end else begin
                if (o_issue_tag !== e.tag) begin
                    report_mismatch("o_issue_tag", 32'(e.tag), 32'(o_issue_tag));
                end
                if (o_issue_rdy0 !== e.rdy0) begin
                    report_mismatch("o_issue_rdy0", 32'(e.rdy0), 32'(o_issue_rdy0));
                end
                if (o_issue_rdy1 !== e.rdy1) begin
                    report_mismatch("o_issue_rdy1", 32'(e.rdy1), 32'(o_issue_rdy1));
                end
                // Data matters only when ready and the tag only when waiting
                if (e.rdy0 && o_issue_data0 !== e.data0) begin
                    report_mismatch("o_issue_data0", e.data0, o_issue_data0);
                end
                if (e.rdy1 && o_issue_data1 !== e.data1) begin
                    report_mismatch("o_issue_data1", e.data1, o_issue_data1);
                end
                if (!e.rdy0 && o_issue_src_tag0 !== e.src_tag0) begin
                    report_mismatch("o_issue_src_tag0", 32'(e.src_tag0), 32'(o_issue_src_tag0));
                end
                if (!e.rdy1 && o_issue_src_tag1 !== e.src_tag1) begin
                    report_mismatch("o_issue_src_tag1", 32'(e.src_tag1), 32'(o_issue_src_tag1));
                end
            end
        end
    endtask

    task automatic check_retire();
        logic expect_retire;
        expect_retire = (m_count > 0) && m_rob_done[m_head];
        if (o_retire_valid !== expect_retire) begin
            report_mismatch("o_retire_valid", 32'(expect_retire), 32'(o_retire_valid));
        end else if (expect_retire) begin
            retire_checks++;
            if (o_retire_rdest !== m_rob_rdest[m_head]) begin
                report_mismatch("o_retire_rdest", 32'(m_rob_rdest[m_head]), 32'(o_retire_rdest));
            end
            if (o_retire_data !== m_rob_data[m_head]) begin
                report_mismatch("o_retire_data", m_rob_data[m_head], o_retire_data);
            end
        end
    endtask

    // The falling edge compares settled outputs and then steps the model
    always @(negedge clk) begin
        if (n_rst) begin
            check_issue();
            check_retire();
            if (o_rob_full !== (m_count == ROB_DEPTH)) begin
                report_mismatch("o_rob_full", 32'(m_count == ROB_DEPTH), 32'(o_rob_full));
            end
            model_edge();
        end
    end

    task automatic drive(input logic dv, input procyon_reg_t s0, input procyon_reg_t s1,
                         input procyon_reg_t rd, input logic cv, input procyon_tag_t ct,
                         input procyon_data_t cd, input logic fl);
        i_dispatch_valid <= dv;
        i_dispatch_rsrc0 <= s0;
        i_dispatch_rsrc1 <= s1;
        i_dispatch_rdest <= rd;
        i_cdb_valid      <= cv;
        i_cdb_tag        <= ct;
        i_cdb_data       <= cd;
        i_flush          <= fl;
    endtask

    task automatic dispatch(input procyon_reg_t s0, input procyon_reg_t s1,
                            input procyon_reg_t rd);
        @(posedge clk);
        drive(1'b1, s0, s1, rd, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic flush_pipeline();
        @(posedge clk);
        drive(1'b0, '0, '0, '0, 1'b0, '0, '0, 1'b1);
    endtask

    // Picks an outstanding tag after the edge once the model has caught up
    task automatic complete_entry(input int pick);
        procyon_tag_t tag;
        int           idx;
        @(posedge clk);
        if (pending.size() == 0) begin
            drive(1'b0, '0, '0, '0, 1'b0, '0, '0, 1'b0);
        end else begin
            if (pick == PICK_OLDEST) idx = 0;
            else if (pick == PICK_NEWEST) idx = pending.size() - 1;
            else idx = int'(rand_bits(3)) % pending.size();
            tag = pending[idx];
            pending.delete(idx);
            drive(1'b0, '0, '0, '0, 1'b1, tag, rand_bits(32), 1'b0);
        end
    endtask

    // Idles until the buffer holds n entries and every issue was seen
    task automatic wait_rob_count(input int n, input string what);
        int cycles;
        cycles = 0;
        do begin
            if (cycles == WAIT_LIMIT) begin
                errors++;
                $display("Timeout after %0d cycles waiting for %s", cycles, what);
                end_run();
            end
            @(posedge clk);
            drive(1'b0, '0, '0, '0, 1'b0, '0, '0, 1'b0);
            cycles++;
        end while (m_count != n || exp_issue.size() != 0);
    endtask

    task automatic complete_all(input string what);
        do complete_entry(PICK_RANDOM);
        while (pending.size() != 0);
        wait_rob_count(0, what);
    endtask

    task automatic report_test(input int n, input string name, input int start);
        tests_run++;
        $display("Test %0d %s %s", n, name, (errors == start) ? "ok" : "with errors");
    endtask

    task automatic end_run();
        $display("Summary tests %0d issue checks %0d retire checks %0d errors %0d",
                 tests_run, issue_checks, retire_checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        int start;
        for (int r = 0; r < REG_COUNT; r++) begin
            m_tag[r]  = '0;
            m_data[r] = '0;
        end
        m_rdy = '1;
        m_rob_done = '0;
        m_head = '0;
        m_tail = '0;
        m_count = 0;
        repeat (16) @(posedge clk);
        n_rst <= 1'b1;

        // Fresh map gives ready zero operands with destinations r16 to r19
        start = errors;
        for (int i = 0; i < 4; i++) begin
            dispatch(procyon_reg_t'(rand_bits(4)), procyon_reg_t'(rand_bits(4)),
                     procyon_reg_t'(16 + i));
        end
        wait_rob_count(4, "issue of the first dispatches");
        report_test(1, "reset state and tag order", start);

        // Readers of renamed registers wait on the producer tags
        start = errors;
        dispatch(5'd16, 5'd17, 5'd20);
        dispatch(5'd18, 5'd19, 5'd0);
        wait_rob_count(6, "issue of the dependent dispatches");
        report_test(2, "rename dependency", start);

        start = errors;
        complete_all("drain after random completion");
        dispatch(5'd16, 5'd17, 5'd0);
        dispatch(5'd18, 5'd20, 5'd0);
        complete_all("drain of the readers");
        // Eight writers fill the buffer before any of them completes
        for (int i = 0; i < ROB_DEPTH; i++) begin
            dispatch(procyon_reg_t'(rand_bits(4)), procyon_reg_t'(rand_bits(4)),
                     procyon_reg_t'(8 + i));
        end
        wait_rob_count(ROB_DEPTH, "a full buffer");
        complete_all("drain of the full buffer");
        report_test(3, "in order retire", start);

        // The younger producer completes while the older one blocks retire
        start = errors;
        dispatch(5'd1, 5'd2, 5'd21);
        dispatch(5'd3, 5'd4, 5'd22);
        complete_entry(PICK_NEWEST);
        dispatch(5'd22, 5'd21, 5'd23);
        complete_all("drain after bypass");
        report_test(4, "operand bypass", start);

        start = errors;
        dispatch(5'd0, 5'd0, 5'd24);
        dispatch(5'd0, 5'd0, 5'd24);
        complete_entry(PICK_OLDEST);
        wait_rob_count(1, "retire of the older writer");
        dispatch(5'd24, 5'd0, 5'd0);
        dispatch(5'd0, 5'd24, 5'd0);
        complete_all("drain of the double rename");
        dispatch(5'd24, 5'd0, 5'd0);
        complete_all("drain of the final reader");
        report_test(5, "double rename and r0", start);

        // Retire known values first so the flush has something to restore
        start = errors;
        dispatch(5'd5, 5'd0, 5'd25);
        dispatch(5'd25, 5'd0, 5'd26);
        complete_all("drain before flush");
        dispatch(5'd0, 5'd0, 5'd25);
        dispatch(5'd25, 5'd0, 5'd26);
        dispatch(5'd26, 5'd25, 5'd27);
        complete_entry(PICK_RANDOM);
        flush_pipeline();
        dispatch(5'd25, 5'd26, 5'd27);
        dispatch(5'd27, 5'd0, 5'd28);
        complete_all("drain after flush");
        report_test(6, "flush recovery", start);

        end_run();
    end

endmodule

//--- vlog.f
hdl/procyon_pkg.sv
hdl/register_map.sv
hdl/reorder_buffer.sv
hdl/dispatch_stage.sv
hdl/rename_top.sv
dv/tb_rename_top.sv

//--- Makefile
# Verilator build and run for the rename subsystem

VERILATOR ?= verilator
TOP       ?= tb_rename_top
RTL_TOP   ?= rename_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only when the simulation output holds the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
